// ==== hw/dbus_params.svh ====
`ifndef DBUS_PARAMS_SVH
`define DBUS_PARAMS_SVH

// number of thread lanes served by the data bus
`define DBUS_NUM_THREADS 4

// bytes per data word
`define DBUS_WORD_SIZE 4

// request and response tag width
`define DBUS_TAG_WIDTH 8

// shared-memory window, given as a byte end address and a byte size
// the window spans [BASE - SIZE, BASE)
`define DBUS_SMEM_BASE 32'hFF00_0000
`define DBUS_SMEM_SIZE 32'h0000_4000

`endif

// ==== hw/dbus_pkg.sv ====
`include "dbus_params.svh"

package dbus_pkg;

    // byte offset bits dropped from a byte address
    localparam int word_shift = $clog2(`DBUS_WORD_SIZE);

    // word address width
    localparam int addr_w = 32 - word_shift;

    // data bits per thread
    localparam int data_w = `DBUS_WORD_SIZE * 8;

    // window bounds in word units, lo inclusive, hi exclusive
    localparam logic [addr_w-1:0] smem_lo =
        addr_w'((`DBUS_SMEM_BASE - `DBUS_SMEM_SIZE) >> word_shift);
    localparam logic [addr_w-1:0] smem_hi =
        addr_w'(`DBUS_SMEM_BASE >> word_shift);

    // one lane request
    typedef struct packed {
        logic [addr_w-1:0]              addr;
        logic                           rw;
        logic [`DBUS_WORD_SIZE-1:0]     byteen;
        logic [data_w-1:0]              data;
        logic [`DBUS_TAG_WIDTH-1:0]     tag;
    } req_t;

    // one response bundle covering all threads
    typedef struct packed {
        logic [`DBUS_NUM_THREADS-1:0]               tmask;
        logic [`DBUS_NUM_THREADS-1:0][data_w-1:0]   data;
        logic [`DBUS_TAG_WIDTH-1:0]                 tag;
    } rsp_t;

endpackage

// ==== hw/skid_buffer.sv ====
`timescale 1ns/1ps

module skid_buffer #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst_n,

    input  logic valid_in,
    input  T     data_in,
    output logic ready_in,

    output logic valid_out,
    output T     data_out,
    input  logic ready_out
);

    logic main_valid;
    T     main_data;
    logic skid_full;
    T     skid_data;

    // main register may load this cycle
    logic main_load;
    // incoming word must park in the skid register
    logic skid_load;

    assign main_load = ready_out || !main_valid;
    assign skid_load = valid_in && !skid_full && !main_load;

    // ready comes straight from a flop, so the input side never sees ready_out
    assign ready_in  = ~skid_full;

    assign valid_out = main_valid;
    assign data_out  = main_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            main_valid <= 1'b0;
            skid_full  <= 1'b0;
        end else if (main_load) begin
            // skid entry is older, drain it first
            main_valid <= skid_full || valid_in;
            skid_full  <= 1'b0;
        end else if (skid_load) begin
            skid_full  <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (main_load) begin
            if (skid_full) begin
                main_data <= skid_data;
            end else begin
                main_data <= data_in;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (skid_load) begin
            skid_data <= data_in;
        end
    end

endmodule

// ==== hw/lane_router.sv ====
`timescale 1ns/1ps
`include "dbus_params.svh"

module lane_router (
    input  logic                                clk,
    input  logic                                rst_n,

    // core side of one lane
    input  logic                                in_valid,
    input  logic [dbus_pkg::addr_w-1:0]         in_addr,
    input  logic                                in_rw,
    input  logic [`DBUS_WORD_SIZE-1:0]          in_byteen,
    input  logic [dbus_pkg::data_w-1:0]         in_data,
    input  logic [`DBUS_TAG_WIDTH-1:0]          in_tag,
    output logic                                in_ready,

    // cache side
    output logic                                cache_valid,
    output dbus_pkg::req_t                      cache_req,
    input  logic                                cache_ready,

    // shared-memory side
    output logic                                smem_valid,
    output dbus_pkg::req_t                      smem_req,
    input  logic                                smem_ready
);

    import dbus_pkg::*;

    req_t req;
    logic is_smem;
    logic cache_in_ready;
    logic smem_in_ready;

    assign req = '{
        addr:   in_addr,
        rw:     in_rw,
        byteen: in_byteen,
        data:   in_data,
        tag:    in_tag
    };

    // window check on the word address
    assign is_smem = (in_addr >= smem_lo) && (in_addr < smem_hi);

    skid_buffer #(
        .T (req_t)
    ) u_cache_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (in_valid && !is_smem),
        .data_in   (req),
        .ready_in  (cache_in_ready),
        .valid_out (cache_valid),
        .data_out  (cache_req),
        .ready_out (cache_ready)
    );

    skid_buffer #(
        .T (req_t)
    ) u_smem_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (in_valid && is_smem),
        .data_in   (req),
        .ready_in  (smem_in_ready),
        .valid_out (smem_valid),
        .data_out  (smem_req),
        .ready_out (smem_ready)
    );

    // a full buffer only holds back requests headed its way
    assign in_ready = is_smem ? smem_in_ready : cache_in_ready;

endmodule

// ==== hw/rsp_arbiter.sv ====
`timescale 1ns/1ps
`include "dbus_params.svh"

module rsp_arbiter (
    input  logic                                                clk,
    input  logic                                                rst_n,

    // cache response bundle
    input  logic [`DBUS_NUM_THREADS-1:0]                        cache_valid,
    input  logic [`DBUS_NUM_THREADS-1:0][dbus_pkg::data_w-1:0]  cache_data,
    input  logic [`DBUS_TAG_WIDTH-1:0]                          cache_tag,
    output logic                                                cache_ready,

    // shared-memory response bundle
    input  logic [`DBUS_NUM_THREADS-1:0]                        smem_valid,
    input  logic [`DBUS_NUM_THREADS-1:0][dbus_pkg::data_w-1:0]  smem_data,
    input  logic [`DBUS_TAG_WIDTH-1:0]                          smem_tag,
    output logic                                                smem_ready,

    // merged bundle to the core
    output logic [`DBUS_NUM_THREADS-1:0]                        out_valid,
    output logic [`DBUS_NUM_THREADS-1:0][dbus_pkg::data_w-1:0]  out_data,
    output logic [`DBUS_TAG_WIDTH-1:0]                          out_tag,
    input  logic                                                out_ready
);

    import dbus_pkg::*;

    logic cache_any;
    logic smem_any;
    // 0 favours the cache, 1 favours shared memory
    logic prio_smem;
    logic grant_smem;
    logic sel_valid;
    rsp_t sel_rsp;

    logic buf_ready;
    logic buf_valid;
    rsp_t buf_rsp;

    // a bundle is on offer when any thread bit is set
    assign cache_any = |cache_valid;
    assign smem_any  = |smem_valid;

    assign grant_smem = smem_any && (!cache_any || prio_smem);
    assign sel_valid  = cache_any || smem_any;

    always_comb begin
        if (grant_smem) begin
            sel_rsp = '{tmask: smem_valid, data: smem_data, tag: smem_tag};
        end else begin
            sel_rsp = '{tmask: cache_valid, data: cache_data, tag: cache_tag};
        end
    end

    assign cache_ready = buf_ready && cache_any && !grant_smem;
    assign smem_ready  = buf_ready && grant_smem;

    // hand priority to the source that just lost
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prio_smem <= 1'b0;
        end else if (sel_valid && buf_ready) begin
            prio_smem <= !grant_smem;
        end
    end

    skid_buffer #(
        .T (rsp_t)
    ) u_out_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (sel_valid),
        .data_in   (sel_rsp),
        .ready_in  (buf_ready),
        .valid_out (buf_valid),
        .data_out  (buf_rsp),
        .ready_out (out_ready)
    );

    assign out_valid = buf_rsp.tmask & {`DBUS_NUM_THREADS{buf_valid}};
    assign out_data  = buf_rsp.data;
    assign out_tag   = buf_rsp.tag;

endmodule

// ==== hw/dbus_arb.sv ====
`timescale 1ns/1ps
`include "dbus_params.svh"

module dbus_arb (
    input  logic                                                clk,
    input  logic                                                rst_n,

    // core requests, one slot per lane
    input  logic [`DBUS_NUM_THREADS-1:0]                        core_req_valid,
    input  logic [`DBUS_NUM_THREADS-1:0][dbus_pkg::addr_w-1:0]  core_req_addr,
    input  logic [`DBUS_NUM_THREADS-1:0]                        core_req_rw,
    input  logic [`DBUS_NUM_THREADS-1:0][`DBUS_WORD_SIZE-1:0]   core_req_byteen,
    input  logic [`DBUS_NUM_THREADS-1:0][dbus_pkg::data_w-1:0]  core_req_data,
    input  logic [`DBUS_NUM_THREADS-1:0][`DBUS_TAG_WIDTH-1:0]   core_req_tag,
    output logic [`DBUS_NUM_THREADS-1:0]                        core_req_ready,

    // cache requests
    output logic [`DBUS_NUM_THREADS-1:0]                        cache_req_valid,
    output logic [`DBUS_NUM_THREADS-1:0][dbus_pkg::addr_w-1:0]  cache_req_addr,
    output logic [`DBUS_NUM_THREADS-1:0]                        cache_req_rw,
    output logic [`DBUS_NUM_THREADS-1:0][`DBUS_WORD_SIZE-1:0]   cache_req_byteen,
    output logic [`DBUS_NUM_THREADS-1:0][dbus_pkg::data_w-1:0]  cache_req_data,
    output logic [`DBUS_NUM_THREADS-1:0][`DBUS_TAG_WIDTH-1:0]   cache_req_tag,
    input  logic [`DBUS_NUM_THREADS-1:0]                        cache_req_ready,

    // shared-memory requests
    output logic [`DBUS_NUM_THREADS-1:0]                        smem_req_valid,
    output logic [`DBUS_NUM_THREADS-1:0][dbus_pkg::addr_w-1:0]  smem_req_addr,
    output logic [`DBUS_NUM_THREADS-1:0]                        smem_req_rw,
    output logic [`DBUS_NUM_THREADS-1:0][`DBUS_WORD_SIZE-1:0]   smem_req_byteen,
    output logic [`DBUS_NUM_THREADS-1:0][dbus_pkg::data_w-1:0]  smem_req_data,
    output logic [`DBUS_NUM_THREADS-1:0][`DBUS_TAG_WIDTH-1:0]   smem_req_tag,
    input  logic [`DBUS_NUM_THREADS-1:0]                        smem_req_ready,

    // cache response bundle
    input  logic [`DBUS_NUM_THREADS-1:0]                        cache_rsp_valid,
    input  logic [`DBUS_NUM_THREADS-1:0][dbus_pkg::data_w-1:0]  cache_rsp_data,
    input  logic [`DBUS_TAG_WIDTH-1:0]                          cache_rsp_tag,
    output logic                                                cache_rsp_ready,

    // shared-memory response bundle
    input  logic [`DBUS_NUM_THREADS-1:0]                        smem_rsp_valid,
    input  logic [`DBUS_NUM_THREADS-1:0][dbus_pkg::data_w-1:0]  smem_rsp_data,
    input  logic [`DBUS_TAG_WIDTH-1:0]                          smem_rsp_tag,
    output logic                                                smem_rsp_ready,

    // merged response to the core
    output logic [`DBUS_NUM_THREADS-1:0]                        core_rsp_valid,
    output logic [`DBUS_NUM_THREADS-1:0][dbus_pkg::data_w-1:0]  core_rsp_data,
    output logic [`DBUS_TAG_WIDTH-1:0]                          core_rsp_tag,
    input  logic                                                core_rsp_ready
);

    import dbus_pkg::*;

    // request path, one router per lane
    for (genvar i = 0; i < `DBUS_NUM_THREADS; i++) begin : g_lane
        req_t cache_req;
        req_t smem_req;

        lane_router u_lane_router (
            .clk         (clk),
            .rst_n       (rst_n),
            .in_valid    (core_req_valid[i]),
            .in_addr     (core_req_addr[i]),
            .in_rw       (core_req_rw[i]),
            .in_byteen   (core_req_byteen[i]),
            .in_data     (core_req_data[i]),
            .in_tag      (core_req_tag[i]),
            .in_ready    (core_req_ready[i]),
            .cache_valid (cache_req_valid[i]),
            .cache_req   (cache_req),
            .cache_ready (cache_req_ready[i]),
            .smem_valid  (smem_req_valid[i]),
            .smem_req    (smem_req),
            .smem_ready  (smem_req_ready[i])
        );

        assign cache_req_addr[i]   = cache_req.addr;
        assign cache_req_rw[i]     = cache_req.rw;
        assign cache_req_byteen[i] = cache_req.byteen;
        assign cache_req_data[i]   = cache_req.data;
        assign cache_req_tag[i]    = cache_req.tag;

        assign smem_req_addr[i]    = smem_req.addr;
        assign smem_req_rw[i]      = smem_req.rw;
        assign smem_req_byteen[i]  = smem_req.byteen;
        assign smem_req_data[i]    = smem_req.data;
        assign smem_req_tag[i]     = smem_req.tag;
    end

    // response path
    rsp_arbiter u_rsp_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .cache_valid (cache_rsp_valid),
        .cache_data  (cache_rsp_data),
        .cache_tag   (cache_rsp_tag),
        .cache_ready (cache_rsp_ready),
        .smem_valid  (smem_rsp_valid),
        .smem_data   (smem_rsp_data),
        .smem_tag    (smem_rsp_tag),
        .smem_ready  (smem_rsp_ready),
        .out_valid   (core_rsp_valid),
        .out_data    (core_rsp_data),
        .out_tag     (core_rsp_tag),
        .out_ready   (core_rsp_ready)
    );

endmodule

// ==== verif/dbus_checker.sv ====
`timescale 1ns/1ps
`include "dbus_params.svh"

module dbus_checker (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic [`DBUS_NUM_THREADS-1:0]                        core_req_valid,
    input  logic [`DBUS_NUM_THREADS-1:0][dbus_pkg::addr_w-1:0]  core_req_addr,
    input  logic [`DBUS_NUM_THREADS-1:0]                        core_req_rw,
    input  logic [`DBUS_NUM_THREADS-1:0][`DBUS_WORD_SIZE-1:0]   core_req_byteen,
    input  logic [`DBUS_NUM_THREADS-1:0][dbus_pkg::data_w-1:0]  core_req_data,
    input  logic [`DBUS_NUM_THREADS-1:0][`DBUS_TAG_WIDTH-1:0]   core_req_tag,
    input  logic [`DBUS_NUM_THREADS-1:0]                        core_req_ready,
    input  logic [`DBUS_NUM_THREADS-1:0]                        cache_req_valid,
    input  logic [`DBUS_NUM_THREADS-1:0][dbus_pkg::addr_w-1:0]  cache_req_addr,
    input  logic [`DBUS_NUM_THREADS-1:0]                        cache_req_rw,
    input  logic [`DBUS_NUM_THREADS-1:0][`DBUS_WORD_SIZE-1:0]   cache_req_byteen,
    input  logic [`DBUS_NUM_THREADS-1:0][dbus_pkg::data_w-1:0]  cache_req_data,
    input  logic [`DBUS_NUM_THREADS-1:0][`DBUS_TAG_WIDTH-1:0]   cache_req_tag,
    input  logic [`DBUS_NUM_THREADS-1:0]                        cache_req_ready,
    input  logic [`DBUS_NUM_THREADS-1:0]                        smem_req_valid,
    input  logic [`DBUS_NUM_THREADS-1:0][dbus_pkg::addr_w-1:0]  smem_req_addr,
    input  logic [`DBUS_NUM_THREADS-1:0]                        smem_req_rw,
    input  logic [`DBUS_NUM_THREADS-1:0][`DBUS_WORD_SIZE-1:0]   smem_req_byteen,
    input  logic [`DBUS_NUM_THREADS-1:0][dbus_pkg::data_w-1:0]  smem_req_data,
    input  logic [`DBUS_NUM_THREADS-1:0][`DBUS_TAG_WIDTH-1:0]   smem_req_tag,
    input  logic [`DBUS_NUM_THREADS-1:0]                        smem_req_ready,
    input  logic [`DBUS_NUM_THREADS-1:0]                        cache_rsp_valid,
    input  logic [`DBUS_NUM_THREADS-1:0][dbus_pkg::data_w-1:0]  cache_rsp_data,
    input  logic [`DBUS_TAG_WIDTH-1:0]                          cache_rsp_tag,
    input  logic                                                cache_rsp_ready,
    input  logic [`DBUS_NUM_THREADS-1:0]                        smem_rsp_valid,
    input  logic [`DBUS_NUM_THREADS-1:0][dbus_pkg::data_w-1:0]  smem_rsp_data,
    input  logic [`DBUS_TAG_WIDTH-1:0]                          smem_rsp_tag,
    input  logic                                                smem_rsp_ready,
    input  logic [`DBUS_NUM_THREADS-1:0]                        core_rsp_valid,
    input  logic [`DBUS_NUM_THREADS-1:0][dbus_pkg::data_w-1:0]  core_rsp_data,
    input  logic [`DBUS_TAG_WIDTH-1:0]                          core_rsp_tag,
    input  logic                                                core_rsp_ready,
    input  int                                                  test_id,
    input  logic                                                report,
    output int                                                  errors,
    output int                                                  pass_tests,
    output int                                                  fail_tests,
    output int                                                  pending
);

    import dbus_pkg::*;

    localparam int nt = `DBUS_NUM_THREADS;

    req_t cache_q[nt][$];
    req_t smem_q[nt][$];
    rsp_t rsp_q[$];

    int   err_cnt = 0;
    int   pass_cnt = 0;
    int   fail_cnt = 0;
    int   pend_cnt = 0;
    int   start_errs = 0;
    // source expected to win the next response grant in the fairness test
    logic next_smem = 1'b0;

    assign errors     = err_cnt;
    assign pass_tests = pass_cnt;
    assign fail_tests = fail_cnt;
    assign pending    = pend_cnt;

    // expected destination of a word address, 1 means shared memory
    function automatic logic to_smem(input logic [addr_w-1:0] addr);
        return (addr >= smem_lo) && (addr < smem_hi);
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1:       return "reset values";
            2:       return "routing";
            3:       return "ordering under back-pressure";
            4:       return "response pass-through";
            5:       return "round-robin fairness";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        if (exp !== act) begin
            $display("Mismatch at %0t: %s expected %0h got %0h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic compare_req(input string port, input int lane, input req_t exp,
                               input req_t act);
        check_value($sformatf("%s_addr[%0d]", port, lane), 128'(exp.addr), 128'(act.addr));
        check_value($sformatf("%s_rw[%0d]", port, lane), 128'(exp.rw), 128'(act.rw));
        check_value($sformatf("%s_byteen[%0d]", port, lane), 128'(exp.byteen),
                    128'(act.byteen));
        check_value($sformatf("%s_data[%0d]", port, lane), 128'(exp.data), 128'(act.data));
        check_value($sformatf("%s_tag[%0d]", port, lane), 128'(exp.tag), 128'(act.tag));
    endtask

    // all handshakes are sampled mid-cycle, a transfer happens on the next rising edge
    always @(negedge clk) begin : monitor
        req_t exp_req;
        req_t act_req;
        rsp_t exp_rsp;
        logic c_acc;
        logic s_acc;

        if (rst_n) begin
            for (int l = 0; l < nt; l++) begin
                if (core_req_valid[l] && core_req_ready[l]) begin
                    exp_req = '{addr: core_req_addr[l], rw: core_req_rw[l],
                                byteen: core_req_byteen[l], data: core_req_data[l],
                                tag: core_req_tag[l]};
                    if (to_smem(core_req_addr[l])) begin
                        smem_q[l].push_back(exp_req);
                    end else begin
                        cache_q[l].push_back(exp_req);
                    end
                end
                if (cache_req_valid[l] && cache_req_ready[l]) begin
                    act_req = '{addr: cache_req_addr[l], rw: cache_req_rw[l],
                                byteen: cache_req_byteen[l], data: cache_req_data[l],
                                tag: cache_req_tag[l]};
                    if (cache_q[l].size() == 0) begin
                        $display("Unexpected cache request on lane %0d at %0t", l, $time);
                        err_cnt++;
                    end else begin
                        compare_req("cache_req", l, cache_q[l].pop_front(), act_req);
                    end
                end
                if (smem_req_valid[l] && smem_req_ready[l]) begin
                    act_req = '{addr: smem_req_addr[l], rw: smem_req_rw[l],
                                byteen: smem_req_byteen[l], data: smem_req_data[l],
                                tag: smem_req_tag[l]};
                    if (smem_q[l].size() == 0) begin
                        $display("Unexpected smem request on lane %0d at %0t", l, $time);
                        err_cnt++;
                    end else begin
                        compare_req("smem_req", l, smem_q[l].pop_front(), act_req);
                    end
                end
            end

            c_acc = (|cache_rsp_valid) && cache_rsp_ready;
            s_acc = (|smem_rsp_valid) && smem_rsp_ready;
            if (c_acc) begin
                rsp_q.push_back('{tmask: cache_rsp_valid, data: cache_rsp_data,
                                  tag: cache_rsp_tag});
            end
            if (s_acc) begin
                rsp_q.push_back('{tmask: smem_rsp_valid, data: smem_rsp_data,
                                  tag: smem_rsp_tag});
            end

            if (test_id != 5) begin
                next_smem = 1'b0;
            end else if (c_acc && s_acc) begin
                $display("Both response sources were granted in one cycle at %0t", $time);
                err_cnt++;
            end else if (c_acc || s_acc) begin
                check_value("rsp_grant_smem", 128'(next_smem), 128'(s_acc));
                next_smem = !s_acc;
            end

            if ((|core_rsp_valid) && core_rsp_ready) begin
                if (rsp_q.size() == 0) begin
                    $display("Unexpected core response bundle at %0t", $time);
                    err_cnt++;
                end else begin
                    exp_rsp = rsp_q.pop_front();
                    check_value("core_rsp_valid", 128'(exp_rsp.tmask), 128'(core_rsp_valid));
                    check_value("core_rsp_data", 128'(exp_rsp.data), 128'(core_rsp_data));
                    check_value("core_rsp_tag", 128'(exp_rsp.tag), 128'(core_rsp_tag));
                end
            end

            if (test_id == 1) begin
                check_value("cache_req_valid", 128'(0), 128'(cache_req_valid));
                check_value("smem_req_valid", 128'(0), 128'(smem_req_valid));
                check_value("core_rsp_valid", 128'(0), 128'(core_rsp_valid));
                check_value("core_req_ready", 128'({nt{1'b1}}), 128'(core_req_ready));
            end

            pend_cnt = rsp_q.size();
            for (int l = 0; l < nt; l++) begin
                pend_cnt = pend_cnt + cache_q[l].size() + smem_q[l].size();
            end
        end

        if (report) begin
            if (err_cnt == start_errs) begin
                pass_cnt++;
                $display("test %0d %s: pass", test_id, test_name(test_id));
            end else begin
                fail_cnt++;
                $display("test %0d %s: fail, %0d errors", test_id, test_name(test_id),
                         err_cnt - start_errs);
            end
            start_errs = err_cnt;
        end
    end

endmodule

// ==== verif/tb_dbus_arb.sv ====
`timescale 1ns/1ps
`include "dbus_params.svh"

module tb_dbus_arb;

    import dbus_pkg::*;

    localparam int nt = `DBUS_NUM_THREADS;
    localparam int max_wait = 2000;

    logic clk;
    logic rst_n;

    logic [nt-1:0]                          core_req_valid;
    logic [nt-1:0][addr_w-1:0]              core_req_addr;
    logic [nt-1:0]                          core_req_rw;
    logic [nt-1:0][`DBUS_WORD_SIZE-1:0]     core_req_byteen;
    logic [nt-1:0][data_w-1:0]              core_req_data;
    logic [nt-1:0][`DBUS_TAG_WIDTH-1:0]     core_req_tag;
    logic [nt-1:0]                          core_req_ready;
    logic [nt-1:0]                          cache_req_valid;
    logic [nt-1:0][addr_w-1:0]              cache_req_addr;
    logic [nt-1:0]                          cache_req_rw;
    logic [nt-1:0][`DBUS_WORD_SIZE-1:0]     cache_req_byteen;
    logic [nt-1:0][data_w-1:0]              cache_req_data;
    logic [nt-1:0][`DBUS_TAG_WIDTH-1:0]     cache_req_tag;
    logic [nt-1:0]                          cache_req_ready;
    logic [nt-1:0]                          smem_req_valid;
    logic [nt-1:0][addr_w-1:0]              smem_req_addr;
    logic [nt-1:0]                          smem_req_rw;
    logic [nt-1:0][`DBUS_WORD_SIZE-1:0]     smem_req_byteen;
    logic [nt-1:0][data_w-1:0]              smem_req_data;
    logic [nt-1:0][`DBUS_TAG_WIDTH-1:0]     smem_req_tag;
    logic [nt-1:0]                          smem_req_ready;
    logic [nt-1:0]                          cache_rsp_valid;
    logic [nt-1:0][data_w-1:0]              cache_rsp_data;
    logic [`DBUS_TAG_WIDTH-1:0]             cache_rsp_tag;
    logic                                   cache_rsp_ready;
    logic [nt-1:0]                          smem_rsp_valid;
    logic [nt-1:0][data_w-1:0]              smem_rsp_data;
    logic [`DBUS_TAG_WIDTH-1:0]             smem_rsp_tag;
    logic                                   smem_rsp_ready;
    logic [nt-1:0]                          core_rsp_valid;
    logic [nt-1:0][data_w-1:0]              core_rsp_data;
    logic [`DBUS_TAG_WIDTH-1:0]             core_rsp_tag;
    logic                                   core_rsp_ready;

    integer seed = 32'h6509;
    int     test_id;
    logic   report;
    int     errors;
    int     pass_tests;
    int     fail_tests;
    int     pending;

    // memory model controls, 0 all ready, 1 random, 2 random cache with smem stalled
    int          req_rdy_mode;
    logic        rsp_en;
    logic        rsp_always;
    logic        core_rdy_rand;
    logic        cache_took;
    logic        smem_took;
    logic [31:0] rdy_rnd;

    dbus_arb u_dbus_arb (.*);

    dbus_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [addr_w-1:0] gen_addr(input int mode);
        logic [31:0] r;
        logic [31:0] r2;
        r  = $random(seed);
        r2 = $random(seed);
        if (mode == 1) begin
            return smem_lo + addr_w'(r2[11:0]);
        end else if (mode == 2) begin
            // top two bits clear keeps the address far below the window
            return addr_w'(r2[addr_w-3:0]);
        end
        case (r[2:0])
            3'd0:    return smem_lo - addr_w'(1);
            3'd1:    return smem_lo;
            3'd2:    return smem_hi - addr_w'(1);
            3'd3:    return smem_hi;
            3'd4:    return smem_lo + addr_w'(r2[11:0]);
            default: return r2[addr_w-1:0];
        endcase
    endfunction

    function automatic rsp_t make_bundle();
        logic [31:0] r;
        rsp_t        b;
        r = $random(seed);
        b.tmask = (r[nt-1:0] == '0) ? {{(nt-1){1'b0}}, 1'b1} : r[nt-1:0];
        b.tag   = r[16 +: `DBUS_TAG_WIDTH];
        for (int t = 0; t < nt; t++) begin
            b.data[t] = $random(seed);
        end
        return b;
    endfunction

    task automatic report_timeout(input string what);
        $display("Timeout: %s did not finish within %0d cycles", what, max_wait);
        $display("TB FAILED");
        $finish;
    endtask

    always @(posedge clk) begin
        rdy_rnd = $random(seed);
        if (req_rdy_mode == 0) begin
            cache_req_ready <= '1;
            smem_req_ready  <= '1;
        end else if (req_rdy_mode == 1) begin
            cache_req_ready <= rdy_rnd[nt-1:0];
            smem_req_ready  <= rdy_rnd[2*nt-1:nt];
        end else begin
            cache_req_ready <= rdy_rnd[nt-1:0];
            smem_req_ready  <= '0;
        end
        core_rsp_ready <= core_rdy_rand ? rdy_rnd[16] : 1'b1;
    end

    always @(negedge clk) begin
        cache_took <= (|cache_rsp_valid) && cache_rsp_ready;
        smem_took  <= (|smem_rsp_valid) && smem_rsp_ready;
    end

    // response models hold a bundle until it is taken
    always @(posedge clk) begin : cache_model
        logic [31:0] r;
        rsp_t        b;
        r = $random(seed);
        if (!(|cache_rsp_valid) || cache_took) begin
            if (rsp_en && (rsp_always || r[0])) begin
                b = make_bundle();
                cache_rsp_valid <= b.tmask;
                cache_rsp_data  <= b.data;
                cache_rsp_tag   <= b.tag;
            end else begin
                cache_rsp_valid <= '0;
            end
        end
    end

    always @(posedge clk) begin : smem_model
        logic [31:0] r;
        rsp_t        b;
        r = $random(seed);
        if (!(|smem_rsp_valid) || smem_took) begin
            if (rsp_en && (rsp_always || r[0])) begin
                b = make_bundle();
                smem_rsp_valid <= b.tmask;
                smem_rsp_data  <= b.data;
                smem_rsp_tag   <= b.tag;
            end else begin
                smem_rsp_valid <= '0;
            end
        end
    end

    // issues n requests per lane, each held until the DUT takes it
    task automatic drive_requests(input int n, input int mode);
        int          issued[nt];
        logic        took[nt];
        int          guard;
        logic        done;
        logic [31:0] r;
        for (int l = 0; l < nt; l++) begin
            issued[l] = 0;
            took[l]   = 1'b0;
        end
        guard = 0;
        done  = 1'b0;
        while (!done) begin
            @(posedge clk);
            for (int l = 0; l < nt; l++) begin
                if (!core_req_valid[l] || took[l]) begin
                    if (issued[l] < n) begin
                        r = $random(seed);
                        core_req_valid[l]  <= 1'b1;
                        core_req_addr[l]   <= gen_addr(mode);
                        core_req_rw[l]     <= r[0];
                        core_req_byteen[l] <= r[4 +: `DBUS_WORD_SIZE];
                        core_req_tag[l]    <= r[16 +: `DBUS_TAG_WIDTH];
                        core_req_data[l]   <= $random(seed);
                        issued[l]++;
                    end else begin
                        core_req_valid[l] <= 1'b0;
                    end
                end
            end
            @(negedge clk);
            done = 1'b1;
            for (int l = 0; l < nt; l++) begin
                took[l] = core_req_valid[l] && core_req_ready[l];
                if (issued[l] < n || (core_req_valid[l] && !took[l])) begin
                    done = 1'b0;
                end
            end
            guard++;
            if (guard > max_wait) begin
                report_timeout("core request handshake");
            end
        end
        @(posedge clk);
        core_req_valid <= '0;
    endtask

    task automatic wait_drain();
        int guard;
        guard = 0;
        @(posedge clk);
        while (pending != 0 || (|cache_rsp_valid) || (|smem_rsp_valid)) begin
            @(posedge clk);
            guard++;
            if (guard > max_wait) begin
                report_timeout("drain of outstanding requests and responses");
            end
        end
    endtask

    task automatic finish_test();
        wait_drain();
        report <= 1'b1;
        @(posedge clk);
        report <= 1'b0;
        @(posedge clk);
    endtask

    initial begin
        rst_n           = 1'b0;
        core_req_valid  = '0;
        core_req_addr   = '0;
        core_req_rw     = '0;
        core_req_byteen = '0;
        core_req_data   = '0;
        core_req_tag    = '0;
        cache_req_ready = '1;
        smem_req_ready  = '1;
        cache_rsp_valid = '0;
        cache_rsp_data  = '0;
        cache_rsp_tag   = '0;
        smem_rsp_valid  = '0;
        smem_rsp_data   = '0;
        smem_rsp_tag    = '0;
        core_rsp_ready  = 1'b1;
        test_id         = 0;
        report          = 1'b0;
        req_rdy_mode    = 0;
        rsp_en          = 1'b0;
        rsp_always      = 1'b0;
        core_rdy_rand   = 1'b0;

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        test_id <= 1;
        repeat (4) @(posedge clk);
        finish_test();

        // fairness runs while the priority pointer still has its reset value
        test_id    <= 5;
        rsp_always <= 1'b1;
        rsp_en     <= 1'b1;
        repeat (40) @(posedge clk);
        rsp_en <= 1'b0;
        finish_test();
        rsp_always <= 1'b0;

        test_id <= 2;
        drive_requests(24, 0);
        finish_test();

        test_id      <= 3;
        req_rdy_mode <= 1;
        drive_requests(40, 0);
        wait_drain();
        // fill every smem buffer, then cache traffic must still get through
        req_rdy_mode <= 2;
        drive_requests(2, 1);
        drive_requests(8, 2);
        req_rdy_mode <= 1;
        finish_test();

        test_id       <= 4;
        req_rdy_mode  <= 0;
        core_rdy_rand <= 1'b1;
        rsp_en        <= 1'b1;
        repeat (200) @(posedge clk);
        rsp_en <= 1'b0;
        finish_test();
        core_rdy_rand <= 1'b0;

        $display("tests passed %0d, failed %0d, errors %0d", pass_tests, fail_tests, errors);
        if (fail_tests == 0 && errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+hw
hw/dbus_pkg.sv
hw/skid_buffer.sv
hw/lane_router.sv
hw/rsp_arbiter.sv
hw/dbus_arb.sv
verif/dbus_checker.sv
verif/tb_dbus_arb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_dbus_arb -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "TB PASSED" \
    && echo "simulation ok" \
    || { echo "simulation not ok"; exit 1; }

exit 0
